// File: verilog/axi_ram_pkg.sv
`default_nettype none

package axi_ram_pkg;

  localparam int DATA_W          = 32;
  localparam int STRB_W          = DATA_W / 8;
  localparam int ADDR_W          = 12;          // 4 KiB of RAM.
  localparam int WORD_W          = ADDR_W - 2;
  localparam int ID_W            = 4;
  localparam int LEN_W           = 8;
  localparam int READ_LATENCY    = 2;
  localparam int FIFO_DEPTH      = 16;
  // Room for every beat still in the RAM pipeline when issue stops.
  localparam int PROG_FULL_LEVEL = FIFO_DEPTH - ((READ_LATENCY + 1 > 3) ? READ_LATENCY + 1 : 3);
  localparam int STARTUP_CYCLES  = 8;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_t;

  typedef union packed {
    logic [ADDR_W-1:0] flat;       // Byte address for wrap math.
    struct packed {
      logic [WORD_W-1:0] word;     // RAM word index.
      logic [1:0]        offset;
    } split;
  } axi_addr_u;

  typedef struct packed {
    logic [ID_W-1:0]  id;
    axi_addr_u        addr;
    logic [LEN_W-1:0] len;
    burst_t           burst;
  } axi_cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    resp_t           resp;
  } axi_b_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_t             resp;
    logic              last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: verilog/axi_ram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_ctrl import axi_ram_pkg::*; (
  input  logic            aximm,
  input  logic            arst_n,
  input  axi_cmd_t        aw,
  input  logic            awvalid,
  output logic            awready,
  input  axi_cmd_t        ar,
  input  logic            arvalid,
  output logic            arready,
  input  logic            wlast,
  input  logic            wvalid,
  output logic            wready,
  output axi_b_t          b,
  output logic            bvalid,
  input  logic            bready,
  output logic            wr_load,
  output logic            wr_step,
  input  logic            wr_last,
  output logic            rd_load,
  output logic            rd_step,
  input  logic            rd_last,
  output logic [ID_W-1:0] rd_id,
  input  logic            prog_full
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    READ
  } state_t;

  state_t                              state;
  logic [$clog2(STARTUP_CYCLES+1)-1:0] startup_cnt;
  logic                                started;
  logic                                wr_held;
  logic                                rd_held;
  logic [READ_LATENCY-1:0]             rd_tail;    // Last read still in the RAM pipe.
  logic [ID_W-1:0]                     b_id;

  assign started = (startup_cnt == STARTUP_CYCLES);
  assign awready = started && !wr_held;
  assign arready = started && !rd_held && (rd_tail == '0);
  assign wr_load = awvalid && awready;
  assign rd_load = arvalid && arready;
  assign wready  = (state == WRITE) && !bvalid;
  assign wr_step = wvalid && wready;
  assign rd_step = (state == READ) && !prog_full;
  assign b.id    = b_id;
  assign b.resp  = OKAY;

  always_ff @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      startup_cnt <= '0;
      wr_held     <= 1'b0;
      rd_held     <= 1'b0;
      rd_tail     <= '0;
      bvalid      <= 1'b0;
    end else begin
      if (!started) startup_cnt <= startup_cnt + 1'b1;
      if (wr_load) wr_held <= 1'b1;
      else if (bvalid && bready) wr_held <= 1'b0;
      if (rd_load) rd_held <= 1'b1;
      else if (rd_step && rd_last) rd_held <= 1'b0;
      rd_tail <= (rd_step && rd_last) ? '1 : rd_tail >> 1;
      if (wr_step && wr_last) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
    end
  end

  always_ff @(posedge aximm) begin
    if (wr_load) b_id <= aw.id;
    if (rd_load) rd_id <= ar.id;
  end

  // Writes win when both commands are held.
  always_ff @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (wr_held) state <= WRITE;
          else if (rd_held) state <= READ;
        end
        WRITE: if (bvalid && bready) state <= rd_held ? READ : IDLE;
        READ: if (rd_step && rd_last) state <= wr_held ? WRITE : IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  wlast_matches_len: assert property (@(posedge aximm) disable iff (!arst_n)
    wr_step |-> (wlast == wr_last))
    else $error("wlast does not agree with the AWLEN beat count");

endmodule

`default_nettype wire

// File: verilog/axi_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr import axi_ram_pkg::*; (
  input  logic      aximm,
  input  logic      arst_n,
  input  axi_cmd_t  cmd,
  input  logic      load,
  input  logic      step,
  output axi_addr_u addr,
  output logic      last
);

  axi_addr_u         cur;
  axi_addr_u         inc_word;
  axi_addr_u         nxt;
  burst_t            burst_q;
  logic [LEN_W-1:0]  len_q;
  logic [LEN_W-1:0]  beat;
  logic [ADDR_W-1:0] wrap_mask;

  assign wrap_mask = ((ADDR_W'(len_q) + 1'b1) << 2) - 1'b1;  // Window size minus one.

  always_comb begin
    inc_word              = cur;
    inc_word.split.word   = cur.split.word + 1'b1;
    inc_word.split.offset = 2'b00;
    case (burst_q)
      INCR:    nxt = inc_word;
      WRAP:    nxt.flat = (cur.flat & ~wrap_mask) | (inc_word.flat & wrap_mask);
      default: nxt = cur;
    endcase
  end

  always_ff @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      beat <= '0;
    end else if (load) begin
      beat <= '0;
    end else if (step) begin
      beat <= beat + 1'b1;
    end
  end

  always_ff @(posedge aximm) begin
    if (load) begin
      cur     <= cmd.addr;
      len_q   <= cmd.len;
      burst_q <= cmd.burst;
    end else if (step) begin
      cur <= nxt;
    end
  end

  assign addr = cur;
  assign last = (beat == len_q);

  wrap_len_legal: assert property (@(posedge aximm) disable iff (!arst_n)
    (load && cmd.burst == WRAP) |-> (cmd.len inside {8'd1, 8'd3, 8'd7, 8'd15}))
    else $error("WRAP burst with illegal length %0d", cmd.len + 1);

endmodule

`default_nettype wire

// File: verilog/axi_ram_sram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_sram import axi_ram_pkg::*; (
  input  logic              aximm,
  input  logic              we,
  input  logic [STRB_W-1:0] strb,
  input  logic [WORD_W-1:0] waddr,
  input  logic [WORD_W-1:0] raddr,
  input  logic [DATA_W-1:0] wdata,
  input  logic              re,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] mem [2**WORD_W];
  logic [DATA_W-1:0] pipe [READ_LATENCY];

  always_ff @(posedge aximm) begin
    if (we) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (strb[i]) mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge aximm) begin
    if (re) pipe[0] <= mem[raddr];
    for (int s = 1; s < READ_LATENCY; s++) begin
      pipe[s] <= pipe[s-1];     // Output register chain.
    end
  end

  assign rdata = pipe[READ_LATENCY-1];

endmodule

`default_nettype wire

// File: verilog/axi_read_align.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_align import axi_ram_pkg::*; (
  input  logic aximm,
  input  logic arst_n,
  input  logic issue,
  input  logic issue_last,
  output logic push,
  output logic push_last
);

  logic [READ_LATENCY-1:0] vld_line;
  logic [READ_LATENCY-1:0] last_line;

  always_ff @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      vld_line  <= '0;
      last_line <= '0;
    end else begin
      vld_line  <= (vld_line << 1) | READ_LATENCY'(issue);
      last_line <= (last_line << 1) | READ_LATENCY'(issue && issue_last);
    end
  end

  // Oldest stage lines up with the RAM output.
  assign push      = vld_line[READ_LATENCY-1];
  assign push_last = last_line[READ_LATENCY-1];

endmodule

`default_nettype wire

// File: verilog/axi_read_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_fifo import axi_ram_pkg::*; (
  input  logic   aximm,
  input  logic   arst_n,
  input  logic   push,
  input  axi_r_t din,
  output logic   prog_full,
  output axi_r_t r,
  output logic   rvalid,
  input  logic   rready
);

  axi_r_t                          buffer [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;
  logic                            pop;
  logic                            full;

  assign full      = (count == FIFO_DEPTH);
  assign prog_full = (count >= PROG_FULL_LEVEL);
  assign pop       = (count != '0) && (!rvalid || rready);  // Output stage free or draining.

  always_ff @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rvalid <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (pop) rvalid <= 1'b1;
      else if (rready) rvalid <= 1'b0;
    end
  end

  always_ff @(posedge aximm) begin
    if (push) buffer[wr_ptr] <= din;
    if (pop) r <= buffer[rd_ptr];
  end

  // Holds only if ctrl respects prog_full.
  no_overflow: assert property (@(posedge aximm) disable iff (!arst_n)
    push |-> !full)
    else $error("read FIFO overflow");

endmodule

`default_nettype wire

// File: verilog/axi_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_top import axi_ram_pkg::*; (
  input  logic     aximm,
  input  logic     arst_n,
  input  axi_cmd_t aw,
  input  logic     awvalid,
  output logic     awready,
  input  axi_w_t   w,
  input  logic     wvalid,
  output logic     wready,
  output axi_b_t   b,
  output logic     bvalid,
  input  logic     bready,
  input  axi_cmd_t ar,
  input  logic     arvalid,
  output logic     arready,
  output axi_r_t   r,
  output logic     rvalid,
  input  logic     rready
);

  logic              wr_load;
  logic              wr_step;
  logic              wr_last;
  logic              rd_load;
  logic              rd_step;
  logic              rd_last;
  logic [ID_W-1:0]   rd_id;
  logic              prog_full;
  axi_addr_u         wr_addr;
  axi_addr_u         rd_addr;
  logic [DATA_W-1:0] ram_rdata;
  logic              push;
  logic              push_last;
  axi_r_t            fifo_din;

  axi_ram_ctrl u_ctrl (
    .aximm, .arst_n, .aw, .awvalid, .awready, .ar, .arvalid, .arready,
    .wlast(w.last), .wvalid, .wready, .b, .bvalid, .bready,
    .wr_load, .wr_step, .wr_last, .rd_load, .rd_step, .rd_last, .rd_id, .prog_full
  );

  axi_burst_addr u_wr_addr (
    .aximm, .arst_n, .cmd(aw), .load(wr_load), .step(wr_step), .addr(wr_addr), .last(wr_last)
  );

  axi_burst_addr u_rd_addr (
    .aximm, .arst_n, .cmd(ar), .load(rd_load), .step(rd_step), .addr(rd_addr), .last(rd_last)
  );

  axi_ram_sram u_sram (
    .aximm, .we(wr_step), .strb(w.strb), .waddr(wr_addr.split.word),
    .raddr(rd_addr.split.word), .wdata(w.data), .re(rd_step), .rdata(ram_rdata)
  );

  axi_read_align u_align (
    .aximm, .arst_n, .issue(rd_step), .issue_last(rd_last), .push, .push_last
  );

  always_comb begin
    fifo_din.id   = rd_id;
    fifo_din.data = ram_rdata;
    fifo_din.resp = OKAY;
    fifo_din.last = push_last;
  end

  axi_read_fifo u_fifo (
    .aximm, .arst_n, .push, .din(fifo_din), .prog_full, .r, .rvalid, .rready
  );

endmodule

`default_nettype wire

// File: verif/axi_ram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_ram_tb import axi_ram_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int TIMEOUT    = 2000;

  logic     aximm;
  logic     arst_n;
  axi_cmd_t aw;
  logic     awvalid;
  logic     awready;
  axi_w_t   w;
  logic     wvalid;
  logic     wready;
  axi_b_t   b;
  logic     bvalid;
  logic     bready;
  axi_cmd_t ar;
  logic     arvalid;
  logic     arready;
  axi_r_t   r;
  logic     rvalid;
  logic     rready;

  logic [DATA_W-1:0] ref_mem [2**WORD_W];
  logic [DATA_W-1:0] wdata_q [256];
  logic [STRB_W-1:0] wstrb_q [256];
  logic [DATA_W-1:0] exp_data [257];
  logic [DATA_W-1:0] exp_word;
  logic [ID_W-1:0]   exp_bid;
  logic [ID_W-1:0]   exp_rid;
  int                exp_len;
  int                r_total;
  int                r_base;
  int                r_beat;
  int                b_total;
  int                since_rst;
  int                errors;
  axi_cmd_t          wcmd;
  axi_cmd_t          rcmd;
  int                b_before;

  axi_ram_top axi_ram_top_inst (
    .aximm, .arst_n, .aw, .awvalid, .awready, .w, .wvalid, .wready,
    .b, .bvalid, .bready, .ar, .arvalid, .arready, .r, .rvalid, .rready
  );

  initial begin
    aximm = 1'b0;
    forever #(CLK_PERIOD/2) aximm = ~aximm;
  end

  always @(posedge aximm or negedge arst_n) begin
    if (!arst_n) begin
      since_rst <= 0;
      r_total   <= 0;
      b_total   <= 0;
    end else begin
      if (since_rst < 1000) since_rst <= since_rst + 1;  // Mirrors the startup count.
      if (rvalid && rready) r_total <= r_total + 1;
      if (bvalid && bready) b_total <= b_total + 1;
    end
  end

  assign r_beat   = r_total - r_base;
  assign exp_word = exp_data[r_beat];

  reset_quiet: assert property (@(posedge aximm) !arst_n |-> (!bvalid && !rvalid))
    else begin
      errors++;
      $display("bvalid or rvalid went high during reset");
    end

  startup_hold: assert property (@(posedge aximm) disable iff (!arst_n)
    (since_rst < STARTUP_CYCLES) |-> (!awready && !arready))
    else begin
      errors++;
      $display("address ready rose before the startup count ran out");
    end

  startup_done: assert property (@(posedge aximm) disable iff (!arst_n)
    (since_rst == STARTUP_CYCLES) |-> (awready && arready))
    else begin
      errors++;
      $display("address ready still low after the startup count");
    end

  rdata_ok: assert property (@(posedge aximm) disable iff (!arst_n)
    (rvalid && rready) |-> (r.data == exp_word))
    else begin
      errors++;
      $display("FAIL rdata beat %0d exp %h got %h", $sampled(r_beat), $sampled(exp_word),
               $sampled(r.data));
    end

  rid_ok: assert property (@(posedge aximm) disable iff (!arst_n)
    (rvalid && rready) |-> (r.id == exp_rid && r.resp == OKAY))
    else begin
      errors++;
      $display("FAIL rid/rresp exp %h/%h got %h/%h", $sampled(exp_rid), OKAY,
               $sampled(r.id), $sampled(r.resp));
    end

  rlast_ok: assert property (@(posedge aximm) disable iff (!arst_n)
    (rvalid && rready) |-> (r.last == (r_beat == exp_len)))
    else begin
      errors++;
      $display("FAIL rlast beat %0d exp %h got %h", $sampled(r_beat),
               $sampled(r_beat == exp_len), $sampled(r.last));
    end

  r_no_extra: assert property (@(posedge aximm) disable iff (!arst_n)
    rvalid |-> (r_beat <= exp_len))
    else begin
      errors++;
      $display("R channel offered a beat beyond the end of the burst");
    end

  r_hold: assert property (@(posedge aximm) disable iff (!arst_n)
    (rvalid && !rready) |=> (rvalid && $stable(r)))
    else begin
      errors++;
      $display("R beat dropped or changed while rready was low");
    end

  bid_ok: assert property (@(posedge aximm) disable iff (!arst_n)
    (bvalid && bready) |-> (b.id == exp_bid && b.resp == OKAY))
    else begin
      errors++;
      $display("FAIL bid/bresp exp %h/%h got %h/%h", $sampled(exp_bid), OKAY,
               $sampled(b.id), $sampled(b.resp));
    end

  task automatic finish_run();
    $display("R beats %0d, B responses %0d, errors %0d", r_total, b_total, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
    finish_run();
  endtask

  // Word index of beat k, from the AXI burst rules.
  function automatic int beat_word(input axi_cmd_t cmd, input int k);
    int start;
    int size;
    int base;
    start = int'(cmd.addr.flat) & ~3;
    size  = (int'(cmd.len) + 1) * 4;
    base  = start & ~(size - 1);
    case (cmd.burst)
      FIXED:   return start >> 2;
      WRAP:    return (base + ((start - base + 4 * k) % size)) >> 2;
      default: return ((start >> 2) + k) % (2**WORD_W);
    endcase
  endfunction

  function automatic axi_cmd_t make_cmd(input logic [ADDR_W-1:0] addr, input int len,
                                        input burst_t burst);
    axi_cmd_t cmd;
    cmd.id        = ID_W'($urandom);
    cmd.addr.flat = addr;
    cmd.len       = LEN_W'(len);
    cmd.burst     = burst;
    return cmd;
  endfunction

  task automatic fill_wdata(input int len, input logic rand_strb);
    for (int k = 0; k <= len; k++) begin
      wdata_q[k] = $urandom;
      wstrb_q[k] = rand_strb ? STRB_W'($urandom) : '1;
    end
  endtask

  task automatic apply_write(input axi_cmd_t cmd);
    int idx;
    for (int k = 0; k <= int'(cmd.len); k++) begin
      idx = beat_word(cmd, k);
      for (int i = 0; i < STRB_W; i++) begin
        if (wstrb_q[k][i]) ref_mem[idx][8*i +: 8] = wdata_q[k][8*i +: 8];
      end
    end
    exp_bid = cmd.id;
  endtask

  task automatic expect_read(input axi_cmd_t cmd);
    for (int k = 0; k <= int'(cmd.len); k++) begin
      exp_data[k] = ref_mem[beat_word(cmd, k)];
    end
    exp_rid = cmd.id;
    exp_len = int'(cmd.len);
    r_base  = r_total;
  endtask

  // Ready is a registered output, so it is sampled mid-cycle.
  task automatic send_cmds(input logic do_aw, input axi_cmd_t aw_cmd,
                           input logic do_ar, input axi_cmd_t ar_cmd);
    int   t;
    logic aw_hs;
    logic ar_hs;
    aw      = aw_cmd;
    ar      = ar_cmd;
    awvalid = do_aw;
    arvalid = do_ar;
    t       = 0;
    while (awvalid || arvalid) begin
      @(negedge aximm);
      aw_hs = awvalid && awready;
      ar_hs = arvalid && arready;
      @(posedge aximm);
      #1;
      if (aw_hs) awvalid = 1'b0;
      if (ar_hs) arvalid = 1'b0;
      t++;
      if ((awvalid || arvalid) && t >= TIMEOUT) timed_out("an address handshake");
    end
  endtask

  task automatic send_w(input int len);
    int   t;
    logic hs;
    for (int k = 0; k <= len; k++) begin
      w.data = wdata_q[k];
      w.strb = wstrb_q[k];
      w.last = (k == len);
      wvalid = 1'b1;
      hs     = 1'b0;
      t      = 0;
      while (!hs) begin
        @(negedge aximm);
        hs = wready;
        @(posedge aximm);
        #1;
        t++;
        if (!hs && t >= TIMEOUT) timed_out("a W handshake");
      end
    end
    wvalid = 1'b0;
  endtask

  task automatic wait_b(input int count_before);
    int t;
    t = 0;
    while (b_total == count_before) begin
      @(posedge aximm);
      #1;
      t++;
      if (t >= TIMEOUT) timed_out("the write response");
    end
  endtask

  task automatic collect_r(input logic backpressure);
    int t;
    t = 0;
    while (r_beat <= exp_len) begin
      // A long stall first fills the FIFO to prog_full.
      rready = backpressure ? (t >= 2 * FIFO_DEPTH && $urandom_range(0, 1) != 0) : 1'b1;
      @(posedge aximm);
      #1;
      t++;
      if (t >= TIMEOUT) timed_out("the R beats");
    end
    rready = 1'b0;
  endtask

  task automatic write_burst(input axi_cmd_t cmd);
    int count_before;
    count_before = b_total;
    apply_write(cmd);
    send_cmds(1'b1, cmd, 1'b0, cmd);
    send_w(int'(cmd.len));
    wait_b(count_before);
  endtask

  task automatic read_burst(input axi_cmd_t cmd, input logic backpressure);
    expect_read(cmd);
    send_cmds(1'b0, cmd, 1'b1, cmd);
    collect_r(backpressure);
  endtask

  initial begin
    void'($urandom(55753));
    arst_n  = 1'b0;
    aw      = '0;
    awvalid = 1'b0;
    w       = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    ar      = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    exp_len = 0;
    exp_bid = '0;
    exp_rid = '0;
    r_base  = 0;
    errors  = 0;
    repeat (10) @(posedge aximm);
    #1;
    arst_n = 1'b1;
    bready = 1'b1;

    // Full words first, so random strobes never leave unknown bytes.
    fill_wdata(31, 1'b0);
    write_burst(make_cmd(12'h100, 31, INCR));
    fill_wdata(15, 1'b1);
    write_burst(make_cmd(12'h100, 15, INCR));
    read_burst(make_cmd(12'h100, 15, INCR), 1'b0);

    read_burst(make_cmd(12'h10e, 3, WRAP), 1'b0);
    read_burst(make_cmd(12'h114, 7, WRAP), 1'b0);

    fill_wdata(3, 1'b0);
    for (int k = 0; k < 4; k++) begin
      wstrb_q[k] = STRB_W'(1 << k);                   // One byte lane per beat.
    end
    write_burst(make_cmd(12'h200, 3, FIXED));
    read_burst(make_cmd(12'h200, 3, FIXED), 1'b0);

    read_burst(make_cmd(12'h100, 15, INCR), 1'b1);
    read_burst(make_cmd(12'h100, 31, INCR), 1'b1);   // Longer than the FIFO, so issue pauses.

    // Same-cycle AW and AR, the write lands first.
    wcmd = make_cmd(12'h300, 3, INCR);
    rcmd = make_cmd(12'h300, 3, INCR);
    fill_wdata(3, 1'b0);
    b_before = b_total;
    apply_write(wcmd);
    expect_read(rcmd);
    send_cmds(1'b1, wcmd, 1'b1, rcmd);
    send_w(3);
    wait_b(b_before);
    collect_r(1'b0);

    repeat (10) @(posedge aximm);
    finish_run();
  end

endmodule

`default_nettype wire

// File: axi_ram.f
verilog/axi_ram_pkg.sv
verilog/axi_ram_ctrl.sv
verilog/axi_burst_addr.sv
verilog/axi_ram_sram.sv
verilog/axi_read_align.sv
verilog/axi_read_fifo.sv
verilog/axi_ram_top.sv
verif/axi_ram_tb.sv

// File: Bender.yml
package:
  name: axi_ram

sources:
  - verilog/axi_ram_pkg.sv
  - verilog/axi_ram_ctrl.sv
  - verilog/axi_burst_addr.sv
  - verilog/axi_ram_sram.sv
  - verilog/axi_read_align.sv
  - verilog/axi_read_fifo.sv
  - verilog/axi_ram_top.sv
  - target: test
    files:
      - verif/axi_ram_tb.sv
